// ==== verilog/lp_pkg.sv ====
/* register map, CSR bit layout and the structs passed between the printer port blocks
   default parameter values and the interrupt vector */

package lp_pkg;

   // word select, compared against wb_adr_i[1]
   localparam logic LP_ADR_CSR = 1'b0;   // control/status
   localparam logic LP_ADR_DAT = 1'b1;   // data, write only

   localparam int LP_FILTER_LEN_DEF  = 4;     // busy/err run length
   localparam int LP_INIT_CYCLES_DEF = 255;   // INIT pulse width in clocks

   localparam logic [8:0] LP_VECTOR = 9'o200;   // vector for the host side

   // ********************************************************************
   // CSR views
   // ********************************************************************

   // read side of CSR
   typedef struct packed {
      logic       error;     // 15 printer error
      logic [6:0] zero_hi;   // 14..8
      logic       drq;       // 7 ready for a byte
      logic       ie;        // 6 interrupt enable
      logic       done;      // 5 transfer finished
      logic [4:0] zero_lo;   // 4..0
   } lp_csr_rd_t;

   // write side of CSR
   typedef struct packed {
      logic       unused_15;
      logic       reset;       // 14 pulse INIT to the printer
      logic [6:0] unused_hi;   // 13..7
      logic       ie;          // 6
      logic       done_set;    // 5 forces an interrupt request
      logic [4:0] unused_lo;
   } lp_csr_wr_t;

   // one CSR word, two decodings
   typedef union packed {
      lp_csr_rd_t rd;
      lp_csr_wr_t wr;
   } lp_csr_u;

   // ********************************************************************
   // block to block bundles
   // ********************************************************************

   typedef struct packed {
      logic drq;
      logic done;
      logic err;    // filtered error line, active high
   } lp_status_t;

   typedef struct packed {
      logic       valid;   // one clock per data write
      logic [7:0] data;
   } lp_wr_t;

   typedef struct packed {
      logic ie;          // level
      logic done_set;    // pulse
      logic init_req;    // pulse
   } lp_ctl_t;

endpackage

// ==== verilog/lp_line_filter.sv ====
/* input filter for the printer busy and error lines */

`timescale 1ns/10ps

module lp_line_filter #(
   parameter int FILTER_LEN = lp_pkg::LP_FILTER_LEN_DEF   // needs 2 or more
) (
   input  logic wb_clk_i,
   input  logic wb_rst_i,
   input  logic lp_busy_i,    // raw from the connector
   input  logic lp_err_n_i,
   output logic busy_o,       // filtered
   output logic err_n_o
);

   // bit 0 busy, bit 1 err_n
   localparam logic [1:0] IDLE_LVL = 2'b10;   // not busy, no error

   logic [1:0]                 line_in;
   logic [1:0]                 line_out;
   logic [1:0][FILTER_LEN-1:0] hist;          // sample history per line

   assign line_in = {lp_err_n_i, lp_busy_i};

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         for (int i = 0; i < 2; i++) begin
            hist[i]     <= {FILTER_LEN{IDLE_LVL[i]}};
            line_out[i] <= IDLE_LVL[i];
         end
      end else begin
         for (int i = 0; i < 2; i++) begin
            hist[i] <= {hist[i][FILTER_LEN-2:0], line_in[i]};   // shift in

            // move only on a full run, hold otherwise
            if (&hist[i]) begin
               line_out[i] <= 1'b1;
            end else if (~|hist[i]) begin
               line_out[i] <= 1'b0;
            end
         end
      end
   end

   assign busy_o  = line_out[0];
   assign err_n_o = line_out[1];

endmodule

// ==== verilog/lp_wb_regs.sv ====
/* Wishbone slave of the printer port
   ack, register decode, CSR read-back, IE bit and write pulses */

`timescale 1ns/10ps

module lp_wb_regs (
   input  logic               wb_clk_i,
   input  logic               wb_rst_i,

   // Wishbone
   input  logic [1:0]         wb_adr_i,
   input  logic [15:0]        wb_dat_i,
   output logic [15:0]        wb_dat_o,
   input  logic               wb_cyc_i,
   input  logic               wb_we_i,
   input  logic               wb_stb_i,
   output logic               wb_ack_o,

   // to/from the transfer engine and irq machine
   input  lp_pkg::lp_status_t status_i,
   output lp_pkg::lp_wr_t     wr_o,
   output lp_pkg::lp_ctl_t    ctl_o
);

   import lp_pkg::*;

   logic       bus_req;     // cycle and strobe both up
   logic       reply;       // ack flop
   logic       rd_stb;
   logic       csr_wstb;
   logic       dat_wstb;
   logic       ie;
   logic       done_set;
   logic       init_req;
   logic       wr_valid;
   logic [7:0] wr_byte;
   lp_csr_u    csr_wr;      // incoming CSR write
   lp_csr_u    csr_rd;      // CSR as software reads it

   // *******************************************************************
   // ack
   // *******************************************************************

   assign bus_req = wb_cyc_i & wb_stb_i;

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         reply <= 1'b0;
      end else begin
         reply <= bus_req;   // clears as soon as stb goes away
      end
   end

   assign wb_ack_o = reply & bus_req;

   // single shot per cycle, ack masks the second clock
   assign rd_stb   = bus_req & ~wb_we_i & ~wb_ack_o;
   assign csr_wstb = bus_req & wb_we_i & ~wb_ack_o & (wb_adr_i[1] == LP_ADR_CSR);
   assign dat_wstb = bus_req & wb_we_i & ~wb_ack_o & (wb_adr_i[1] == LP_ADR_DAT);

   // *******************************************************************
   // read path
   // *******************************************************************

   always_comb begin
      csr_rd         = '0;            // unused bits read as zero
      csr_rd.rd.error = status_i.err;
      csr_rd.rd.drq   = status_i.drq;
      csr_rd.rd.ie    = ie;
      csr_rd.rd.done  = status_i.done;
   end

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         wb_dat_o <= '0;
      end else if (rd_stb) begin
         // data register has no read-back
         wb_dat_o <= (wb_adr_i[1] == LP_ADR_CSR) ? csr_rd : 16'h0000;
      end
   end

   // *******************************************************************
   // write path
   // *******************************************************************

   assign csr_wr = wb_dat_i;

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         ie       <= 1'b0;
         done_set <= 1'b0;
         init_req <= 1'b0;
         wr_valid <= 1'b0;
      end else begin
         if (csr_wstb) begin
            ie <= csr_wr.wr.ie;
         end
         done_set <= csr_wstb & csr_wr.wr.done_set;   // one clock pulses
         init_req <= csr_wstb & csr_wr.wr.reset;
         wr_valid <= dat_wstb;                        // engine decides if it takes it
      end
   end

   // byte itself, only low lane matters
   always_ff @(posedge wb_clk_i) begin
      if (dat_wstb) begin
         wr_byte <= wb_dat_i[7:0];
      end
   end

   assign wr_o  = '{valid: wr_valid, data: wr_byte};
   assign ctl_o = '{ie: ie, done_set: done_set, init_req: init_req};

endmodule

// ==== verilog/lp_strobe_ctrl.sv ====
/* byte transfer engine of the printer port
   acceptance, data latch, strobe sequence, DRQ/DONE and the INIT timer */

`timescale 1ns/10ps

module lp_strobe_ctrl #(
   parameter int INIT_CYCLES = lp_pkg::LP_INIT_CYCLES_DEF
) (
   input  logic               wb_clk_i,
   input  logic               wb_rst_i,
   input  lp_pkg::lp_wr_t     wr_i,         // data write pulse
   input  lp_pkg::lp_ctl_t    ctl_i,
   input  logic               busy_i,       // filtered
   input  logic               err_n_i,      // filtered
   output lp_pkg::lp_status_t status_o,
   output logic               done_rise_o,  // transfer finished
   output logic [7:0]         lp_data_o,
   output logic               lp_stb_n_o,
   output logic               lp_init_n_o
);

   localparam int CNT_W = $clog2(INIT_CYCLES + 1);

   logic             drq;
   logic             done;
   logic             accept;
   logic [CNT_W-1:0] init_cnt;   // INIT low while nonzero

   // printer must be idle and healthy, anything else is dropped
   assign accept = wr_i.valid & drq & ~busy_i & err_n_i;

   // *******************************************************************
   // strobe sequence
   // *******************************************************************

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         drq         <= 1'b0;   // set on first clock out of reset
         done        <= 1'b0;
         lp_stb_n_o  <= 1'b1;
         done_rise_o <= 1'b0;
      end else begin
         done_rise_o <= 1'b0;

         if (accept) begin
            drq        <= 1'b0;
            done       <= 1'b0;
            lp_stb_n_o <= 1'b0;   // strobe out
         end

         // printer took the byte
         if (!drq && !lp_stb_n_o && busy_i) begin
            lp_stb_n_o <= 1'b1;
         end

         // printer finished with it
         if (!drq && lp_stb_n_o && !busy_i) begin
            drq         <= 1'b1;
            done        <= 1'b1;
            done_rise_o <= 1'b1;
         end
      end
   end

   always_ff @(posedge wb_clk_i) begin
      if (accept) begin
         lp_data_o <= wr_i.data;   // held until the next byte
      end
   end

   // *******************************************************************
   // INIT timer
   // *******************************************************************

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         init_cnt <= CNT_W'(INIT_CYCLES);
      end else if (ctl_i.init_req) begin
         init_cnt <= CNT_W'(INIT_CYCLES);   // restart full width
      end else if (init_cnt != '0) begin
         init_cnt <= init_cnt - 1'b1;
      end
   end

   assign lp_init_n_o = (init_cnt == '0);

   assign status_o = '{drq: drq, done: done, err: ~err_n_i};

endmodule

// ==== verilog/lp_irq_ctrl.sv ====
/* interrupt trigger and request/acknowledge FSM */

`timescale 1ns/10ps

module lp_irq_ctrl (
   input  logic            wb_clk_i,
   input  logic            wb_rst_i,
   input  lp_pkg::lp_ctl_t ctl_i,
   input  logic            done_rise_i,
   input  logic            iack_i,
   output logic            irq_o
);

   typedef enum logic [1:0] {
      IRQ_IDLE = 2'd0,   // nothing pending on the bus
      IRQ_REQ  = 2'd1,   // irq_o up
      IRQ_WAIT = 2'd2    // acknowledged, waiting for iack to drop
   } irq_state_t;

   irq_state_t state;
   logic       trigger;   // pending request
   logic       trig_clr;

   assign trig_clr = (state == IRQ_REQ) & ctl_i.ie & iack_i;

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         trigger <= 1'b0;
      end else if (done_rise_i | ctl_i.done_set) begin
         trigger <= 1'b1;   // new event wins over the clear
      end else if (trig_clr) begin
         trigger <= 1'b0;
      end
   end

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         state <= IRQ_IDLE;
         irq_o <= 1'b0;
      end else begin
         case (state)
            IRQ_IDLE: begin
               if (ctl_i.ie && trigger) begin
                  state <= IRQ_REQ;
                  irq_o <= 1'b1;
               end else begin
                  irq_o <= 1'b0;
               end
            end
            IRQ_REQ: begin
               if (!ctl_i.ie) begin
                  state <= IRQ_IDLE;   // request withdrawn
                  irq_o <= 1'b0;
               end else if (iack_i) begin
                  state <= IRQ_WAIT;
                  irq_o <= 1'b0;
               end
            end
            IRQ_WAIT: begin
               if (!iack_i) begin
                  state <= IRQ_IDLE;
               end
            end
            default: begin
               state <= IRQ_IDLE;
               irq_o <= 1'b0;
            end
         endcase
      end
   end

endmodule

// ==== verilog/lp_port.sv ====
/* printer port top level
   line filter, Wishbone registers, transfer engine and interrupt FSM */

`timescale 1ns/10ps

module lp_port #(
   parameter int FILTER_LEN  = lp_pkg::LP_FILTER_LEN_DEF,
   parameter int INIT_CYCLES = lp_pkg::LP_INIT_CYCLES_DEF
) (
   input  logic        wb_clk_i,
   input  logic        wb_rst_i,

   // Wishbone slave
   input  logic [1:0]  wb_adr_i,
   input  logic [15:0] wb_dat_i,
   output logic [15:0] wb_dat_o,
   input  logic        wb_cyc_i,
   input  logic        wb_we_i,
   input  logic        wb_stb_i,
   output logic        wb_ack_o,

   output logic        irq_o,
   input  logic        iack_i,

   // printer connector
   output logic [7:0]  lp_data_o,
   output logic        lp_stb_n_o,
   output logic        lp_init_n_o,
   input  logic        lp_busy_i,
   input  logic        lp_err_n_i
);

   import lp_pkg::*;

   logic       busy;        // filtered lines
   logic       err_n;
   lp_status_t status;
   lp_wr_t     wr;
   lp_ctl_t    ctl;
   logic       done_rise;

   lp_line_filter #(
      .FILTER_LEN (FILTER_LEN)
   ) filter0 (
      .wb_clk_i   (wb_clk_i),
      .wb_rst_i   (wb_rst_i),
      .lp_busy_i  (lp_busy_i),
      .lp_err_n_i (lp_err_n_i),
      .busy_o     (busy),
      .err_n_o    (err_n)
   );

   lp_wb_regs regs0 (
      .wb_clk_i (wb_clk_i),
      .wb_rst_i (wb_rst_i),
      .wb_adr_i (wb_adr_i),
      .wb_dat_i (wb_dat_i),
      .wb_dat_o (wb_dat_o),
      .wb_cyc_i (wb_cyc_i),
      .wb_we_i  (wb_we_i),
      .wb_stb_i (wb_stb_i),
      .wb_ack_o (wb_ack_o),
      .status_i (status),
      .wr_o     (wr),
      .ctl_o    (ctl)
   );

   lp_strobe_ctrl #(
      .INIT_CYCLES (INIT_CYCLES)
   ) xfer0 (
      .wb_clk_i    (wb_clk_i),
      .wb_rst_i    (wb_rst_i),
      .wr_i        (wr),
      .ctl_i       (ctl),
      .busy_i      (busy),
      .err_n_i     (err_n),
      .status_o    (status),
      .done_rise_o (done_rise),
      .lp_data_o   (lp_data_o),
      .lp_stb_n_o  (lp_stb_n_o),
      .lp_init_n_o (lp_init_n_o)
   );

   lp_irq_ctrl irq0 (
      .wb_clk_i    (wb_clk_i),
      .wb_rst_i    (wb_rst_i),
      .ctl_i       (ctl),
      .done_rise_i (done_rise),
      .iack_i      (iack_i),
      .irq_o       (irq_o)
   );

endmodule

// ==== verification/lp_printer_model.sv ====
/* behavioural line printer
   answers the strobe with busy, holds a forced error and logs received bytes */

`timescale 1ns/10ps

module lp_printer_model (
   input  logic       clk_i,
   input  logic       rst_i,
   input  logic       stb_n_i,
   input  logic [7:0] data_i,
   input  logic       err_force_i,   // hold the error line
   output logic       busy_o,
   output logic       err_n_o
);

   logic [7:0] rx_q[$];   // bytes in arrival order
   integer     seed;
   int         dly;
   int         hold;

   assign err_n_o = ~err_force_i;

   initial begin
      busy_o = 1'b0;
      seed   = 17541;
      forever begin
         @(negedge stb_n_i);
         if (!rst_i) begin
            @(negedge clk_i);
            rx_q.push_back(data_i);                // latched with the strobe
            dly  = 5 + ({$random(seed)} % 16);     // 5..20 clocks
            hold = 8 + ({$random(seed)} % 13);     // long enough for strobe release
            repeat (dly) @(negedge clk_i);
            busy_o = 1'b1;
            repeat (hold) @(negedge clk_i);
            busy_o = 1'b0;
         end
      end
   end

endmodule

// ==== verification/lp_port_tb.sv ====
/* testbench for the printer port
   clock, reset, Wishbone tasks, scenarios, assertions and timeout */

`timescale 1ns/10ps

module lp_port_tb;

   localparam int FILTER_LEN  = lp_pkg::LP_FILTER_LEN_DEF;
   localparam int INIT_CYCLES = lp_pkg::LP_INIT_CYCLES_DEF;
   localparam int NUM_BYTES   = 16;
   localparam int MAX_CYCLES  = 2 * INIT_CYCLES + (NUM_BYTES + 12) * 80 + 1000;
   localparam logic [1:0] ADR_CSR = 2'b00;
   localparam logic [1:0] ADR_DAT = 2'b10;

   logic        wb_clk, wb_rst, wb_cyc, wb_we, wb_stb, wb_ack;
   logic [1:0]  wb_adr;
   logic [15:0] wb_dat_w, wb_dat_r, rd;
   logic        irq, iack, stb_n, init_n, busy_m, err_n, err_force, busy_glitch;
   logic [7:0]  lp_data;
   logic [7:0]  exp_q[$];          // bytes that must reach the printer
   logic        ie_shadow;
   integer      seed;
   int          cycles, irq_cnt, stb_falls, init_pulses, init_low, base;

   lp_port #(.FILTER_LEN(FILTER_LEN), .INIT_CYCLES(INIT_CYCLES)) dut0 (
      .wb_clk_i(wb_clk), .wb_rst_i(wb_rst), .wb_adr_i(wb_adr), .wb_dat_i(wb_dat_w),
      .wb_dat_o(wb_dat_r), .wb_cyc_i(wb_cyc), .wb_we_i(wb_we), .wb_stb_i(wb_stb),
      .wb_ack_o(wb_ack), .irq_o(irq), .iack_i(iack), .lp_data_o(lp_data),
      .lp_stb_n_o(stb_n), .lp_init_n_o(init_n), .lp_busy_i(busy_m | busy_glitch),
      .lp_err_n_i(err_n)
   );

   lp_printer_model printer0 (
      .clk_i(wb_clk), .rst_i(wb_rst), .stb_n_i(stb_n), .data_i(lp_data),
      .err_force_i(err_force), .busy_o(busy_m), .err_n_o(err_n)
   );

   initial begin
      wb_clk = 1'b0;
      forever #2 wb_clk = ~wb_clk;   // 4 ns
   end

   task automatic stop_on_error(input string msg);
      $display("%s", msg);
      $display("Errors found");
      $fatal(1);
   endtask

   task automatic check_eq(input string name, input logic [15:0] got, input logic [15:0] exp);
      assert (got === exp) else
         stop_on_error($sformatf("** Error %s = %h, expected %h", name, got, exp));
   endtask

   // ********************************************************************
   // monitors and assertions
   // ********************************************************************

   always @(posedge wb_clk) begin
      cycles++;
      if (cycles > MAX_CYCLES) stop_on_error("timeout: the run did not finish in time");
   end

   // INIT width measured in clocks
   always @(posedge wb_clk) begin
      if (!wb_rst && !init_n) init_low++;
      if (!wb_rst && init_n && init_low != 0) begin
         check_eq("lp_init_n_o low cycles", init_low, INIT_CYCLES);
         init_low = 0;
         init_pulses++;
      end
   end

   always @(negedge stb_n) if (!wb_rst) stb_falls++;
   always @(posedge irq) irq_cnt++;

   // acknowledge every request a while later
   always begin
      @(posedge irq);
      @(negedge wb_clk);
      iack = 1'b1;
      repeat (3) @(negedge wb_clk);
      iack = 1'b0;
   end

   assert property (@(posedge wb_clk) disable iff (wb_rst) $rose(stb_n) |-> busy_m)
      else stop_on_error("strobe released while the printer was not busy");
   assert property (@(posedge wb_clk) disable iff (wb_rst) irq && iack |=> !irq)
      else stop_on_error("irq_o did not fall one cycle after iack_i");
   assert property (@(posedge wb_clk) disable iff (wb_rst) $rose(irq) |-> !$past(iack))
      else stop_on_error("new interrupt request before iack_i fell");
   assert property (@(posedge wb_clk) disable iff (wb_rst) $rose(irq) |-> ie_shadow)
      else stop_on_error("irq_o rose with interrupts disabled");

   // ********************************************************************
   // bus tasks
   // ********************************************************************

   task automatic wb_cycle(input logic we, input logic [1:0] adr, input logic [15:0] wdat,
                           output logic [15:0] rdat);
      @(negedge wb_clk);
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = we;
      wb_adr   = adr;
      wb_dat_w = wdat;
      #1 check_eq("wb_ack_o", wb_ack, 1'b0);    // not before a clock
      @(negedge wb_clk);
      check_eq("wb_ack_o", wb_ack, 1'b1);       // one clock after stb
      rdat = wb_dat_r;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
      #1 check_eq("wb_ack_o", wb_ack, 1'b0);
   endtask

   task automatic csr_write(input logic [15:0] val);
      logic [15:0] dummy;
      wb_cycle(1'b1, ADR_CSR, val, dummy);
   endtask

   task automatic csr_expect(input logic [15:0] exp);
      logic [15:0] val;
      wb_cycle(1'b0, ADR_CSR, 16'h0000, val);
      check_eq("wb_dat_o (CSR)", val, exp);
   endtask

   task automatic wait_drq;
      logic [15:0] val;
      val = 16'h0000;
      while (!val[7]) wb_cycle(1'b0, ADR_CSR, 16'h0000, val);
   endtask

   // poll DRQ and write one byte, DRQ must drop and a second write must be lost
   task automatic send_byte(input logic [7:0] b, input logic extra);
      logic [15:0] dummy;
      wait_drq();
      wb_cycle(1'b1, ADR_DAT, {8'h00, b}, dummy);
      exp_q.push_back(b);
      csr_expect({9'h000, ie_shadow, 6'h00});   // DRQ and DONE clear
      if (extra) wb_cycle(1'b1, ADR_DAT, 16'h00ff, dummy);
   endtask

   task automatic glitch_busy;
      @(negedge wb_clk) busy_glitch = 1'b1;
      repeat (FILTER_LEN - 1) @(negedge wb_clk);
      busy_glitch = 1'b0;
   endtask

   // ********************************************************************
   // scenarios
   // ********************************************************************

   initial begin
      seed        = 17541;
      cycles      = 0;
      irq_cnt     = 0;
      stb_falls   = 0;
      init_pulses = 0;
      init_low    = 0;
      wb_rst      = 1'b1;
      wb_cyc      = 1'b0;
      wb_stb      = 1'b0;
      wb_we       = 1'b0;
      wb_adr      = 2'b00;
      wb_dat_w    = 16'h0000;
      iack        = 1'b0;
      err_force   = 1'b0;
      busy_glitch = 1'b0;
      ie_shadow   = 1'b0;
      repeat (2) @(posedge wb_clk);
      @(negedge wb_clk) wb_rst = 1'b0;
      check_eq("irq_o", irq, 1'b0);
      check_eq("wb_ack_o", wb_ack, 1'b0);
      check_eq("lp_stb_n_o", stb_n, 1'b1);

      csr_expect(16'h00a0);                       // DRQ and DONE set after reset
      wb_cycle(1'b0, ADR_DAT, 16'h0000, rd);
      check_eq("wb_dat_o (data reg)", rd, 16'h0000);

      for (int i = 0; i < NUM_BYTES; i++) send_byte($random(seed), i[0]);

      // busy glitches while idle and during a strobe
      wait_drq();
      glitch_busy();
      wb_cycle(1'b1, ADR_DAT, 16'h005a, rd);     // lands while a leaky filter still shows busy
      exp_q.push_back(8'h5a);
      glitch_busy();

      // forced error drops writes
      wait_drq();
      @(negedge wb_clk) err_force = 1'b1;
      repeat (FILTER_LEN + 2) @(negedge wb_clk);
      csr_expect(16'h80a0);
      wb_cycle(1'b1, ADR_DAT, 16'h00e7, rd);
      repeat (30) @(negedge wb_clk);
      check_eq("stb falls", stb_falls, exp_q.size());
      err_force = 1'b0;
      repeat (FILTER_LEN + 2) @(negedge wb_clk);
      csr_expect(16'h00a0);

      wait (init_pulses == 1);
      csr_write(16'h4000);                        // second INIT pulse
      wait (init_pulses == 2);

      // interrupts with the pending one from reset first
      ie_shadow = 1'b1;
      base = irq_cnt;
      csr_write(16'h0040);
      wait (irq_cnt == base + 1);
      for (int i = 0; i < 3; i++) begin
         base = irq_cnt;
         send_byte($random(seed), 1'b0);
         wait (irq_cnt == base + 1);
      end
      wait (iack == 1'b0);
      base = irq_cnt;
      csr_write(16'h0060);                        // software DONE
      wait (irq_cnt == base + 1);
      wait (iack == 1'b0);
      csr_write(16'h0000);
      ie_shadow = 1'b0;
      for (int i = 0; i < 2; i++) send_byte($random(seed), 1'b0);
      wait_drq();
      repeat (20) @(negedge wb_clk);

      check_eq("stb falls", stb_falls, exp_q.size());
      check_eq("bytes received", printer0.rx_q.size(), exp_q.size());
      foreach (exp_q[i]) check_eq($sformatf("printer byte %0d", i), printer0.rx_q[i], exp_q[i]);
      $display("No errors");
      $finish;
   end

endmodule

// ==== filelist.f ====
verilog/lp_pkg.sv
verilog/lp_line_filter.sv
verilog/lp_wb_regs.sv
verilog/lp_strobe_ctrl.sv
verilog/lp_irq_ctrl.sv
verilog/lp_port.sv
verification/lp_printer_model.sv
verification/lp_port_tb.sv
